// ==== Bender.yml ====
package:
  name: periph_soc

sources:
  - verilog/soc_pkg.sv
  - verilog/bus_decoder.sv
  - verilog/system_ram.sv
  - verilog/switches.sv
  - verilog/interrupt_controller.sv
  - verilog/segment_display.sv
  - verilog/periph_top.sv
  - target: simulation
    files:
      - verif/periph_sva.sv
      - verif/periph_tb.sv

// ==== filelist.f ====
verilog/soc_pkg.sv
verilog/bus_decoder.sv
verilog/system_ram.sv
verilog/switches.sv
verilog/interrupt_controller.sv
verilog/segment_display.sv
verilog/periph_top.sv
verif/periph_sva.sv
verif/periph_tb.sv

// ==== verif/periph_sva.sv ====
`timescale 1ns/1ns

module periph_sva (
    input logic                            cpu_clk_i,
    input logic                            arst_n_i,
    input soc_pkg::bus_req_t               bus_req_i,
    input soc_pkg::chip_select_t           chip_select_i,
    input logic [soc_pkg::IRQ_SOURCES-1:0] irq_enable_i,
    input logic                            interrupt_i,
    input logic [soc_pkg::DSP_DIGITS-1:0]  dsp_anode_i
);

    int fail_count = 0;

    rd_wr_exclusive: assert property (@(posedge cpu_clk_i) disable iff (!arst_n_i)
        !(bus_req_i.read_enable && bus_req_i.write_enable))
        else begin
            $error("read and write requested in the same cycle");
            fail_count = fail_count + 1;
        end

    select_onehot: assert property (@(posedge cpu_clk_i) disable iff (!arst_n_i)
        $onehot0(chip_select_i))
        else begin
            $error("more than one chip select active");
            fail_count = fail_count + 1;
        end

    // interrupt_o is registered, so the enable must have been zero one edge earlier too
    masked_no_irq: assert property (@(posedge cpu_clk_i) disable iff (!arst_n_i)
        (irq_enable_i == '0 && $past(irq_enable_i) == '0) |-> !interrupt_i)
        else begin
            $error("interrupt raised while all sources are masked");
            fail_count = fail_count + 1;
        end

    anode_onehot: assert property (@(posedge cpu_clk_i) disable iff (!arst_n_i)
        $onehot0(~dsp_anode_i))
        else begin
            $error("more than one display anode driven");
            fail_count = fail_count + 1;
        end

endmodule

bind periph_top periph_sva bus_checks (
    .cpu_clk_i     (cpu_clk_i),
    .arst_n_i      (arst_n_i),
    .bus_req_i     (bus_req_i),
    .chip_select_i (chip_select),
    .irq_enable_i  (irq.enable_q),
    .interrupt_i   (interrupt_o),
    .dsp_anode_i   (dsp_anode_o)
);

// ==== verif/periph_tb.sv ====
`timescale 1ns/1ns

module periph_tb;
    import soc_pkg::*;

    // Active-high gfedcba for F down to 0
    localparam logic [16*7-1:0] FONT_ON = {7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77, 7'h6F,
        7'h7F, 7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F};

    logic                    cpu_clk_i;
    logic                    arst_n_i;
    bus_req_t                bus_req;
    logic [SWITCH_COUNT-1:0] switch_val;
    word_t                   read_data;
    logic                    interrupt;
    logic [DSP_DIGITS-1:0]   anode;
    logic [7:0]              cathode;

    integer      seed = 32'h8e36;
    int          error_count;
    int          timeout_count;
    logic        read_in_flight;
    word_t       expected_q[$];
    word_t       addr_q[$];
    word_t       shadow_ram [RAM_WORDS];
    word_t       shadow_digits;
    logic [7:0]  shadow_dp;
    logic        shadow_dsp_en;
    logic [15:0] shadow_sw;
    logic        shadow_changed;
    logic [1:0]  shadow_pending;
    logic [1:0]  shadow_irq_en;

    periph_top UUT (
        .cpu_clk_i       (cpu_clk_i),
        .arst_n_i        (arst_n_i),
        .bus_req_i       (bus_req),
        .switch_i        (switch_val),
        .bus_read_data_o (read_data),
        .interrupt_o     (interrupt),
        .dsp_anode_o     (anode),
        .dsp_cathode_o   (cathode)
    );

    always #20 cpu_clk_i = ~cpu_clk_i;

    function automatic logic [6:0] hex_font(input logic [3:0] nibble);
        return ~FONT_ON[nibble*7 +: 7];   // Segments are active low
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data,
                                          input logic [3:0] mask);
        word_t merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                merged[b*8 +: 8] = data[b*8 +: 8];
        end
        return merged;
    endfunction

    function automatic word_t expected_read(input word_t addr);
        logic [3:0] offset;
        offset = addr[5:2];
        case (addr[31:28])
            RAM_BASE[31:28]:     return shadow_ram[addr[9:2]];   // Wraps in the region
            DISPLAY_BASE[31:28]: return (offset == REG_VALUE) ? shadow_digits :
                (offset == REG_CONTROL) ? {16'b0, shadow_dp, 7'b0, shadow_dsp_en} : '0;
            SWITCH_BASE[31:28]:  return (offset == REG_VALUE) ? {16'b0, shadow_sw} :
                (offset == REG_CONTROL) ? {31'b0, shadow_changed} : '0;
            IRQ_BASE[31:28]:     return (offset == REG_PENDING) ? {30'b0, shadow_pending} :
                (offset == REG_ENABLE) ? {30'b0, shadow_irq_en} : '0;
            default:             return '0;
        endcase
    endfunction

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("error at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t ns: %s", $time, what);
        timeout_count++;
    endtask

    task automatic write_word(input word_t addr, input word_t data, input logic [3:0] mask);
        logic [3:0] offset;
        offset = addr[5:2];
        @(negedge cpu_clk_i);
        bus_req = {addr, 1'b0, 1'b1, data, mask};   // addr, read, write, data, mask
        case (addr[31:28])
            RAM_BASE[31:28]:
                shadow_ram[addr[9:2]] = merge_bytes(shadow_ram[addr[9:2]], data, mask);
            DISPLAY_BASE[31:28]: begin
                if (offset == REG_VALUE)
                    shadow_digits = merge_bytes(shadow_digits, data, mask);
                if (offset == REG_CONTROL && mask[0])
                    shadow_dsp_en = data[0];
                if (offset == REG_CONTROL && mask[1])
                    shadow_dp = data[15:8];
            end
            SWITCH_BASE[31:28]: begin
                if (offset == REG_CONTROL && mask[0] && data[0])
                    shadow_changed = 1'b0;
            end
            IRQ_BASE[31:28]: begin
                if (offset == REG_PENDING && mask[0])
                    shadow_pending = shadow_pending & ~data[1:0];
                if (offset == REG_ENABLE && mask[0])
                    shadow_irq_en = data[1:0];
            end
            default: ;
        endcase
        @(negedge cpu_clk_i);
        bus_req = '0;
    endtask

    task automatic issue_read(input word_t addr);
        @(negedge cpu_clk_i);
        bus_req = {addr, 1'b1, 1'b0, 32'b0, 4'b0};
        expected_q.push_back(expected_read(addr));
        addr_q.push_back(addr);
    endtask

    task automatic read_word(input word_t addr);
        issue_read(addr);
        @(negedge cpu_clk_i);
        bus_req = '0;
    endtask

    // Pipelined reads at one per cycle
    task automatic alternate_reads(input word_t addr_a, input word_t addr_b, input int count);
        for (int i = 0; i < count; i++)
            issue_read(i[0] ? addr_b : addr_a);
        @(negedge cpu_clk_i);
        bus_req = '0;
    endtask

    task automatic wait_interrupt(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (interrupt !== level && n < max_cycles) begin
            @(negedge cpu_clk_i);
            n++;
        end
        if (interrupt !== level)
            report_timeout($sformatf("interrupt_o never went to %b", level));
    endtask

    task automatic wait_anode(input int digit, input int max_cycles);
        int n;
        n = 0;
        while (anode[digit] !== 1'b0 && n < max_cycles) begin
            @(negedge cpu_clk_i);
            n++;
        end
        if (anode[digit] !== 1'b0)
            report_timeout($sformatf("anode of digit %0d never went low", digit));
    endtask

    always @(posedge cpu_clk_i or negedge arst_n_i) begin
        if (!arst_n_i)
            read_in_flight <= 1'b0;
        else
            read_in_flight <= bus_req.read_enable;
    end

    // Read data is due one cycle after the request
    always @(negedge cpu_clk_i) begin
        if (read_in_flight) begin
            if (expected_q.size() == 0) begin
                $display("read data came back with no read outstanding at %0t ns", $time);
                error_count++;
            end else begin
                check_value(read_data, expected_q.pop_front(),
                            $sformatf("read of %h", addr_q.pop_front()));
            end
        end
    end

    initial begin
        word_t      addr;
        word_t      data;
        logic [3:0] mask;
        int         n;
        cpu_clk_i      = 1'b0;
        arst_n_i       = 1'b0;
        bus_req        = '0;
        switch_val     = '0;
        error_count    = 0;
        timeout_count  = 0;
        shadow_digits  = '0;
        shadow_dp      = '0;
        shadow_dsp_en  = 1'b0;
        shadow_sw      = '0;
        shadow_changed = 1'b0;
        shadow_pending = '0;
        shadow_irq_en  = '0;
        repeat (4) @(negedge cpu_clk_i);
        arst_n_i = 1'b1;
        check_value(interrupt, 1'b0, "interrupt after reset");
        check_value(anode, 8'hFF, "anodes after reset");
        check_value(cathode, 8'hFF, "cathodes after reset");
        read_word(IRQ_BASE + 8);
        read_word(IRQ_BASE + 12);
        read_word(DISPLAY_BASE);
        read_word(DISPLAY_BASE + 4);

        // Full RAM word first so no byte stays undefined
        for (int i = 0; i < 16; i++) begin
            addr = {4'h0, 28'($random(seed))};
            write_word(addr, $random(seed), 4'hF);
            mask = $random(seed);
            write_word(addr, $random(seed), mask);
            read_word(addr);
        end

        read_word(32'h5000_0010);   // Unmapped regions
        read_word(32'hF000_0000);
        write_word(DISPLAY_BASE, $random(seed), 4'hF);
        alternate_reads(addr, DISPLAY_BASE, 6);

        write_word(IRQ_BASE + 12, 32'h1, 4'hF);
        read_word(IRQ_BASE + 12);
        data       = $random(seed);
        switch_val = data[15:0] | 16'h1;   // Must differ from the reset value
        shadow_sw  = switch_val;
        shadow_changed    = 1'b1;
        shadow_pending[0] = 1'b1;
        wait_interrupt(1'b1, 12);
        read_word(SWITCH_BASE);
        read_word(SWITCH_BASE + 4);
        read_word(IRQ_BASE + 8);
        write_word(SWITCH_BASE + 4, 32'h1, 4'h1);
        write_word(IRQ_BASE + 8, 32'h1, 4'h1);
        wait_interrupt(1'b0, 8);
        read_word(IRQ_BASE + 8);

        // Masked source still pends
        write_word(IRQ_BASE + 12, 32'h0, 4'hF);
        switch_val = ~switch_val;
        shadow_sw  = switch_val;
        shadow_changed    = 1'b1;
        shadow_pending[0] = 1'b1;
        for (int i = 0; i < 12; i++) begin
            @(negedge cpu_clk_i);
            check_value(interrupt, 1'b0, "interrupt while masked");
        end
        read_word(SWITCH_BASE);
        read_word(IRQ_BASE + 8);
        write_word(SWITCH_BASE + 4, 32'h1, 4'h1);
        write_word(IRQ_BASE + 8, 32'h1, 4'h1);

        write_word(DISPLAY_BASE, $random(seed), 4'hF);
        data = $random(seed);
        write_word(DISPLAY_BASE + 4, {16'b0, data[7:0], 8'h01}, 4'h3);
        read_word(DISPLAY_BASE);
        read_word(DISPLAY_BASE + 4);
        for (int d = 0; d < 8; d++) begin
            wait_anode(d, 200);
            check_value(cathode, {~shadow_dp[d], hex_font(shadow_digits[d*4 +: 4])},
                        $sformatf("cathodes of digit %0d", d));
        end
        write_word(DISPLAY_BASE + 4, 32'h0, 4'h1);
        @(negedge cpu_clk_i);   // Scanner leaves SCAN_DRIVE on this edge
        for (int i = 0; i < 40; i++) begin
            check_value(anode, 8'hFF, "anodes with display off");
            @(negedge cpu_clk_i);
        end

        n = 0;
        while (expected_q.size() != 0 && n < 4) begin
            @(negedge cpu_clk_i);
            n++;
        end
        if (expected_q.size() != 0)
            report_timeout("some reads never returned data");

        $display("%0d value errors, %0d timeouts, %0d assertion failures",
                 error_count, timeout_count, UUT.bus_checks.fail_count);
        if (error_count == 0 && timeout_count == 0 && UUT.bus_checks.fail_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== verilog/bus_decoder.sv ====
`timescale 1ns/1ns

module bus_decoder (
    input  logic                  cpu_clk_i,
    input  logic                  arst_n_i,
    input  soc_pkg::bus_req_t     bus_req_i,
    input  soc_pkg::word_t        ram_data_i,
    input  soc_pkg::word_t        dsp_data_i,
    input  soc_pkg::word_t        sw_data_i,
    input  soc_pkg::word_t        irq_data_i,
    output soc_pkg::chip_select_t chip_select_o,
    output soc_pkg::word_t        bus_read_data_o
);
    import soc_pkg::*;

    logic [REGION_MSB:REGION_LSB] region;
    logic                         access;
    chip_select_t                 read_select_q;   // Device owning the data in flight

    assign region = bus_req_i.addr[REGION_MSB:REGION_LSB];
    assign access = bus_req_i.read_enable | bus_req_i.write_enable;

    always_comb begin
        chip_select_o = '0;
        if (access) begin
            case (region)
                RAM_BASE[REGION_MSB:REGION_LSB]:     chip_select_o.ram      = 1'b1;
                DISPLAY_BASE[REGION_MSB:REGION_LSB]: chip_select_o.display  = 1'b1;
                SWITCH_BASE[REGION_MSB:REGION_LSB]:  chip_select_o.switches = 1'b1;
                IRQ_BASE[REGION_MSB:REGION_LSB]:     chip_select_o.irq      = 1'b1;
                default:                             chip_select_o          = '0;
            endcase
        end
    end

    // Only reads return data, so writes leave nothing in flight
    always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            read_select_q <= '0;
        end else begin
            read_select_q <= bus_req_i.read_enable ? chip_select_o : '0;
        end
    end

    always_comb begin
        if (read_select_q.ram)
            bus_read_data_o = ram_data_i;
        else if (read_select_q.display)
            bus_read_data_o = dsp_data_i;
        else if (read_select_q.switches)
            bus_read_data_o = sw_data_i;
        else if (read_select_q.irq)
            bus_read_data_o = irq_data_i;
        else
            bus_read_data_o = '0;   // Unmapped or idle
    end

endmodule

// ==== verilog/interrupt_controller.sv ====
`timescale 1ns/1ns

module interrupt_controller (
    input  logic                             cpu_clk_i,
    input  logic                             arst_n_i,
    input  logic                             select_i,
    input  soc_pkg::bus_req_t                bus_req_i,
    input  logic [soc_pkg::IRQ_SOURCES-1:0]  irq_i,       // Level sources
    output soc_pkg::word_t                   read_data_o,
    output logic                             interrupt_o
);
    import soc_pkg::*;

    logic [IRQ_SOURCES-1:0] pending_q;
    logic [IRQ_SOURCES-1:0] enable_q;
    logic [IRQ_SOURCES-1:0] pending_clear;
    logic                   reg_write;
    reg_offset_e            reg_offset;

    assign reg_offset = reg_offset_e'(bus_req_i.addr[REG_IDX_W+WORD_LSB-1:WORD_LSB]);
    assign reg_write  = select_i & bus_req_i.write_enable & bus_req_i.write_mask[0];

    always_comb begin
        pending_clear = '0;
        if (reg_write && reg_offset == REG_PENDING)
            pending_clear = bus_req_i.write_data[IRQ_SOURCES-1:0];
    end

    always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q   <= '0;
            enable_q    <= '0;
            interrupt_o <= 1'b0;
        end else begin
            // A source still high sets its bit again
            pending_q   <= (pending_q & ~pending_clear) | irq_i;
            interrupt_o <= |(pending_q & enable_q);
            if (reg_write && reg_offset == REG_ENABLE)
                enable_q <= bus_req_i.write_data[IRQ_SOURCES-1:0];
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (select_i && bus_req_i.read_enable) begin
            case (reg_offset)
                REG_PENDING: read_data_o <= {{(32-IRQ_SOURCES){1'b0}}, pending_q};
                REG_ENABLE:  read_data_o <= {{(32-IRQ_SOURCES){1'b0}}, enable_q};
                default:     read_data_o <= '0;
            endcase
        end
    end

endmodule

// ==== verilog/periph_top.sv ====
`timescale 1ns/1ns

module periph_top (
    input  logic                             cpu_clk_i,
    input  logic                             arst_n_i,
    input  soc_pkg::bus_req_t                bus_req_i,        // From the CPU master
    input  logic [soc_pkg::SWITCH_COUNT-1:0] switch_i,         // Asynchronous switch bank
    output soc_pkg::word_t                   bus_read_data_o,  // One cycle after the read
    output logic                             interrupt_o,
    output logic [soc_pkg::DSP_DIGITS-1:0]   dsp_anode_o,
    output logic [7:0]                       dsp_cathode_o
);
    import soc_pkg::*;

    chip_select_t chip_select;
    word_t        ram_read_data;
    word_t        dsp_read_data;
    word_t        sw_read_data;
    word_t        irq_read_data;
    logic         sw_irq;

    bus_decoder decoder (
        .cpu_clk_i       (cpu_clk_i),
        .arst_n_i        (arst_n_i),
        .bus_req_i       (bus_req_i),
        .ram_data_i      (ram_read_data),
        .dsp_data_i      (dsp_read_data),
        .sw_data_i       (sw_read_data),
        .irq_data_i      (irq_read_data),
        .chip_select_o   (chip_select),
        .bus_read_data_o (bus_read_data_o)
    );

    // RAM
    system_ram ram (
        .cpu_clk_i   (cpu_clk_i),
        .select_i    (chip_select.ram),
        .bus_req_i   (bus_req_i),
        .read_data_o (ram_read_data)
    );

    // Seven segment display
    segment_display display (
        .cpu_clk_i     (cpu_clk_i),
        .arst_n_i      (arst_n_i),
        .select_i      (chip_select.display),
        .bus_req_i     (bus_req_i),
        .read_data_o   (dsp_read_data),
        .dsp_anode_o   (dsp_anode_o),
        .dsp_cathode_o (dsp_cathode_o)
    );

    // Switch bank
    switches switch_bank (
        .cpu_clk_i   (cpu_clk_i),
        .arst_n_i    (arst_n_i),
        .select_i    (chip_select.switches),
        .bus_req_i   (bus_req_i),
        .switch_i    (switch_i),
        .read_data_o (sw_read_data),
        .irq_o       (sw_irq)
    );

    // Interrupts, spare source held low
    interrupt_controller irq (
        .cpu_clk_i   (cpu_clk_i),
        .arst_n_i    (arst_n_i),
        .select_i    (chip_select.irq),
        .bus_req_i   (bus_req_i),
        .irq_i       ({{(IRQ_SOURCES-1){1'b0}}, sw_irq}),
        .read_data_o (irq_read_data),
        .interrupt_o (interrupt_o)
    );

endmodule

// ==== verilog/segment_display.sv ====
`timescale 1ns/1ns

module segment_display (
    input  logic                            cpu_clk_i,
    input  logic                            arst_n_i,
    input  logic                            select_i,
    input  soc_pkg::bus_req_t               bus_req_i,
    output soc_pkg::word_t                  read_data_o,
    output logic [soc_pkg::DSP_DIGITS-1:0]  dsp_anode_o,     // Active low
    output logic [7:0]                      dsp_cathode_o    // Active low, bit 7 is dp
);
    import soc_pkg::*;

    word_t                  digits_q;       // Eight hex nibbles
    logic                   enable_q;
    logic [DSP_DIGITS-1:0]  dp_q;           // Decimal point per digit
    scan_state_e            state_q;
    logic [SCAN_CNT_W-1:0]  scan_cnt_q;
    logic [DIGIT_IDX_W-1:0] digit_q;
    logic                   reg_write;
    reg_offset_e            reg_offset;

    // Segments g..a, active low
    function automatic logic [6:0] hex_segments(input logic [3:0] nibble);
        case (nibble)
            4'h0: hex_segments = 7'b1000000;
            4'h1: hex_segments = 7'b1111001;
            4'h2: hex_segments = 7'b0100100;
            4'h3: hex_segments = 7'b0110000;
            4'h4: hex_segments = 7'b0011001;
            4'h5: hex_segments = 7'b0010010;
            4'h6: hex_segments = 7'b0000010;
            4'h7: hex_segments = 7'b1111000;
            4'h8: hex_segments = 7'b0000000;
            4'h9: hex_segments = 7'b0010000;
            4'hA: hex_segments = 7'b0001000;
            4'hB: hex_segments = 7'b0000011;
            4'hC: hex_segments = 7'b1000110;
            4'hD: hex_segments = 7'b0100001;
            4'hE: hex_segments = 7'b0000110;
            default: hex_segments = 7'b0001110;
        endcase
    endfunction

    assign reg_offset = reg_offset_e'(bus_req_i.addr[REG_IDX_W+WORD_LSB-1:WORD_LSB]);
    assign reg_write  = select_i & bus_req_i.write_enable;

    always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            digits_q <= '0;
            enable_q <= 1'b0;
            dp_q     <= '0;
        end else if (reg_write) begin
            if (reg_offset == REG_VALUE) begin
                for (int b = 0; b < 4; b++) begin
                    if (bus_req_i.write_mask[b])
                        digits_q[b*8 +: 8] <= bus_req_i.write_data[b*8 +: 8];
                end
            end else if (reg_offset == REG_CONTROL) begin
                if (bus_req_i.write_mask[0])
                    enable_q <= bus_req_i.write_data[0];
                if (bus_req_i.write_mask[1])
                    dp_q <= bus_req_i.write_data[15:8];
            end
        end
    end

    // Blank one cycle, then drive the digit for DSP_SCAN_DIV cycles
    always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= SCAN_BLANK;
            scan_cnt_q <= '0;
            digit_q    <= '0;
        end else if (!enable_q) begin
            state_q    <= SCAN_BLANK;
            scan_cnt_q <= '0;
        end else if (state_q == SCAN_BLANK) begin
            state_q    <= SCAN_DRIVE;
            scan_cnt_q <= '0;
        end else if (scan_cnt_q == SCAN_CNT_W'(DSP_SCAN_DIV - 1)) begin
            state_q <= SCAN_BLANK;
            digit_q <= digit_q + 1'b1;   // Wraps 7 to 0
        end else begin
            scan_cnt_q <= scan_cnt_q + 1'b1;
        end
    end

    always_comb begin
        dsp_anode_o   = '1;
        dsp_cathode_o = '1;
        if (state_q == SCAN_DRIVE) begin
            dsp_anode_o[digit_q] = 1'b0;
            dsp_cathode_o        = {~dp_q[digit_q], hex_segments(digits_q[digit_q*4 +: 4])};
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (select_i && bus_req_i.read_enable) begin
            case (reg_offset)
                REG_VALUE:   read_data_o <= digits_q;
                REG_CONTROL: read_data_o <= {16'b0, dp_q, 7'b0, enable_q};
                default:     read_data_o <= '0;
            endcase
        end
    end

endmodule

// ==== verilog/soc_pkg.sv ====
package soc_pkg;

    // Bus word
    typedef logic [31:0] word_t;

    // One-hot device selects
    typedef struct packed {
        logic ram;
        logic display;
        logic switches;
        logic irq;
    } chip_select_t;

    // Master request, sampled on every rising edge
    typedef struct packed {
        word_t      addr;
        logic       read_enable;
        logic       write_enable;
        word_t      write_data;
        logic [3:0] write_mask;   // One bit per byte lane
    } bus_req_t;

    // Address map, decoded on the top nibble
    localparam int    REGION_MSB   = 31;
    localparam int    REGION_LSB   = 28;
    localparam word_t RAM_BASE     = 32'h0000_0000;
    localparam word_t DISPLAY_BASE = 32'h1000_0000;
    localparam word_t SWITCH_BASE  = 32'h2000_0000;
    localparam word_t IRQ_BASE     = 32'h3000_0000;

    // Word addressing
    localparam int WORD_LSB   = 2;
    localparam int RAM_WORDS  = 256;
    localparam int RAM_ADDR_W = $clog2(RAM_WORDS);   // Index from addr[9:2]

    // Device register word indexes, addr[5:2]
    localparam int REG_IDX_W = 4;
    typedef enum logic [REG_IDX_W-1:0] {
        REG_VALUE   = 4'd0,
        REG_CONTROL = 4'd1,
        REG_PENDING = 4'd2,
        REG_ENABLE  = 4'd3
    } reg_offset_e;

    // Peripherals
    localparam int IRQ_SOURCES   = 2;    // Bit 0 switches, bit 1 spare
    localparam int SWITCH_COUNT  = 16;
    localparam int DSP_DIGITS    = 8;
    localparam int DIGIT_IDX_W   = $clog2(DSP_DIGITS);
    localparam int DSP_SCAN_DIV  = 16;   // Clocks per digit
    localparam int SCAN_CNT_W    = $clog2(DSP_SCAN_DIV);

    typedef enum logic {
        SCAN_BLANK,
        SCAN_DRIVE
    } scan_state_e;

endpackage

// ==== verilog/switches.sv ====
`timescale 1ns/1ns

module switches (
    input  logic                              cpu_clk_i,
    input  logic                              arst_n_i,
    input  logic                              select_i,
    input  soc_pkg::bus_req_t                 bus_req_i,
    input  logic [soc_pkg::SWITCH_COUNT-1:0]  switch_i,    // Asynchronous
    output soc_pkg::word_t                    read_data_o,
    output logic                              irq_o
);
    import soc_pkg::*;

    logic [SWITCH_COUNT-1:0] sw_meta_q;
    logic [SWITCH_COUNT-1:0] sw_sync_q;
    logic [SWITCH_COUNT-1:0] sw_prev_q;   // Previous synchronized sample
    logic                    changed_q;
    logic                    changed_clear;
    reg_offset_e             reg_offset;

    assign reg_offset = reg_offset_e'(bus_req_i.addr[REG_IDX_W+WORD_LSB-1:WORD_LSB]);

    // Write 1 to control bit 0 acknowledges the change
    assign changed_clear = select_i & bus_req_i.write_enable & bus_req_i.write_mask[0]
                         & (reg_offset == REG_CONTROL) & bus_req_i.write_data[0];

    always_ff @(posedge cpu_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sw_meta_q <= '0;
            sw_sync_q <= '0;
            sw_prev_q <= '0;
            changed_q <= 1'b0;
        end else begin
            sw_meta_q <= switch_i;
            sw_sync_q <= sw_meta_q;
            sw_prev_q <= sw_sync_q;
            if (sw_sync_q != sw_prev_q)
                changed_q <= 1'b1;       // A new edge wins over the clear
            else if (changed_clear)
                changed_q <= 1'b0;
        end
    end

    assign irq_o = changed_q;

    always_ff @(posedge cpu_clk_i) begin
        if (select_i && bus_req_i.read_enable) begin
            case (reg_offset)
                REG_VALUE:   read_data_o <= {{(32-SWITCH_COUNT){1'b0}}, sw_sync_q};
                REG_CONTROL: read_data_o <= {31'b0, changed_q};
                default:     read_data_o <= '0;
            endcase
        end
    end

endmodule

// ==== verilog/system_ram.sv ====
`timescale 1ns/1ns

module system_ram (
    input  logic              cpu_clk_i,
    input  logic              select_i,
    input  soc_pkg::bus_req_t bus_req_i,
    output soc_pkg::word_t    read_data_o
);
    import soc_pkg::*;

    word_t                 mem [RAM_WORDS];
    logic [RAM_ADDR_W-1:0] word_idx;   // Wraps inside the region
    logic                  write_hit;
    logic                  read_hit;

    assign word_idx  = bus_req_i.addr[RAM_ADDR_W+WORD_LSB-1:WORD_LSB];
    assign write_hit = select_i & bus_req_i.write_enable;
    assign read_hit  = select_i & bus_req_i.read_enable;

    // Byte lanes under the mask
    always_ff @(posedge cpu_clk_i) begin
        if (write_hit) begin
            for (int b = 0; b < 4; b++) begin
                if (bus_req_i.write_mask[b])
                    mem[word_idx][b*8 +: 8] <= bus_req_i.write_data[b*8 +: 8];
            end
        end
    end

    // One-cycle read, held until the next read
    always_ff @(posedge cpu_clk_i) begin
        if (read_hit)
            read_data_o <= mem[word_idx];
    end

endmodule
